// ==== hdl/mmc1_params.svh ====
`ifndef MMC1_PARAMS_SVH
`define MMC1_PARAMS_SVH

// ==================================================
// address widths
// ==================================================

`define MMC1_PRG_AW 19 // 512K PRG ROM space
`define MMC1_CHR_AW 17 // 128K CHR space
`define MMC1_SRM_AW 15 // 32K save RAM, four 8K banks

// ==================================================
// save-state map
// ==================================================

// addresses 0 to 3 hold r0..r3
`define MMC1_SS_BUF 4 // shift buffer
`define MMC1_SS_ID 127 // mapper number readback

`define MMC1_MAP_NUM 8'd1 // iNES mapper 1

// ==================================================
// serial loader
// ==================================================

// empty buffer, the marker bit reaches bit 0 after four shifts
`define MMC1_BUF_INIT 5'b10000

`endif

// ==== hdl/mmc1_pkg.sv ====
package mmc1_pkg;

	// ==================================================
	// register types
	// ==================================================

	// one mapper register, also the shift buffer
	typedef logic [4:0] mmc1_reg_t;

	// register index, from cpu_addr[14:13]
	typedef logic [1:0] mmc1_idx_t;

	// ==================================================
	// mode fields of r0
	// ==================================================

	// nametable mirroring, r0[1:0]
	typedef enum logic [1:0]
	{
		single_lo  = 2'd0, // one screen, lower page
		single_hi  = 2'd1, // one screen, upper page
		vertical   = 2'd2, // a10 from ppu a10
		horizontal = 2'd3  // a10 from ppu a11
	} mirror_t;

	// PRG banking mode, r0[3:2]
	typedef enum logic [1:0]
	{
		prg_32k_a     = 2'd0, // 32K, low bank bit ignored
		prg_32k_b     = 2'd1, // same as prg_32k_a
		prg_fix_first = 2'd2, // 8000 fixed to bank 0
		prg_fix_last  = 2'd3  // C000 fixed to bank F
	} prg_mode_t;

endpackage

// ==== hdl/mmc1_shift_loader.sv ====
`include "mmc1_params.svh"

module mmc1_shift_loader
(
	input  logic                m2,
	input  logic                map_rst,
	input  logic [15:0]         cpu_addr,
	input  logic [7:0]          cpu_dat,
	input  logic                cpu_rw,
	input  logic                ss_act,
	input  logic                ss_we,
	input  logic [7:0]          ss_addr,
	input  logic [7:0]          ss_wdat,
	output logic                load_en,
	output mmc1_pkg::mmc1_idx_t load_idx,
	output mmc1_pkg::mmc1_reg_t load_val,
	output logic                soft_rst,
	output mmc1_pkg::mmc1_reg_t buff
);

	logic cpu_we;    // serial write on the bus this cycle
	logic reg_we;    // accepted serial write this cycle
	logic reg_we_st; // last cycle held a serial write

	// ==================================================
	// write strobe
	// ==================================================

	assign cpu_we = cpu_addr[15] & ~cpu_rw;

	// RMW instructions write twice in a row, only the first counts
	assign reg_we = cpu_we & ~reg_we_st;

	always_ff @(posedge m2)
	begin
		if (map_rst)
			reg_we_st <= 1'b0;
		else
			reg_we_st <= cpu_we;
	end

	// ==================================================
	// strobes to the register file
	// ==================================================

	assign soft_rst = reg_we & cpu_dat[7]; // bit 7 clears the sequence
	assign load_en  = reg_we & ~cpu_dat[7] & buff[0]; // fifth bit in

	assign load_idx = mmc1_pkg::mmc1_idx_t'(cpu_addr[14:13]);
	assign load_val = {cpu_dat[0], buff[4:1]}; // lsb first

	// ==================================================
	// shift buffer
	// ==================================================

	always_ff @(posedge m2)
	begin
		if (ss_act)
		begin
			if (ss_we && ss_addr == 8'(`MMC1_SS_BUF))
				buff <= ss_wdat[4:0];
		end
		else if (map_rst)
		begin
			buff <= `MMC1_BUF_INIT;
		end
		else if (soft_rst)
		begin
			buff <= `MMC1_BUF_INIT; // partial value dropped
		end
		else if (reg_we)
		begin
			if (buff[0])
				buff <= `MMC1_BUF_INIT; // committed, start over
			else
				buff <= {cpu_dat[0], buff[4:1]};
		end
	end

endmodule

// ==== hdl/mmc1_regs.sv ====
`include "mmc1_params.svh"

module mmc1_regs
(
	input  logic                m2,
	input  logic                map_rst,
	input  logic                load_en,
	input  mmc1_pkg::mmc1_idx_t load_idx,
	input  mmc1_pkg::mmc1_reg_t load_val,
	input  logic                soft_rst,
	input  mmc1_pkg::mmc1_reg_t buff,
	input  logic                ss_act,
	input  logic                ss_we,
	input  logic [7:0]          ss_addr,
	input  logic [7:0]          ss_wdat,
	output mmc1_pkg::mmc1_reg_t r0,
	output mmc1_pkg::mmc1_reg_t r1,
	output mmc1_pkg::mmc1_reg_t r2,
	output mmc1_pkg::mmc1_reg_t r3,
	output logic [7:0]          ss_rdat
);

	mmc1_pkg::mmc1_reg_t map_regs [4];

	logic ss_reg_hit; // save-state address falls on r0..r3

	assign ss_reg_hit = (ss_addr[7:2] == 6'd0);

	// ==================================================
	// register file
	// ==================================================

	always_ff @(posedge m2)
	begin
		if (ss_act)
		begin
			if (ss_we && ss_reg_hit)
				map_regs[ss_addr[1:0]] <= ss_wdat[4:0];
		end
		else if (map_rst)
		begin
			map_regs[0]    <= 5'b11111; // 16K banks, fix last, 4K CHR
			map_regs[3][4] <= 1'b0;     // save RAM on
		end
		else if (soft_rst)
		begin
			map_regs[0][3:2] <= 2'b11; // back to fix-last
		end
		else if (load_en)
		begin
			map_regs[load_idx] <= load_val;
		end
	end

	assign r0 = map_regs[0]; // control
	assign r1 = map_regs[1]; // CHR bank 0
	assign r2 = map_regs[2]; // CHR bank 1
	assign r3 = map_regs[3]; // PRG bank and RAM disable

	// ==================================================
	// save-state readback
	// ==================================================

	always_comb
	begin
		if (ss_reg_hit)
			ss_rdat = {3'b000, map_regs[ss_addr[1:0]]};
		else if (ss_addr == 8'(`MMC1_SS_BUF))
			ss_rdat = {3'b000, buff};
		else if (ss_addr == 8'(`MMC1_SS_ID))
			ss_rdat = `MMC1_MAP_NUM;
		else
			ss_rdat = 8'hff; // unmapped
	end

endmodule

// ==== hdl/mmc1_prg_decode.sv ====
`include "mmc1_params.svh"

module mmc1_prg_decode
(
	input  logic [15:0]              cpu_addr,
	input  logic                     cpu_rw,
	input  mmc1_pkg::mmc1_reg_t      r0,
	input  mmc1_pkg::mmc1_reg_t      r3,
	input  logic [4:0]               chr_bank_hi,
	input  logic                     cfg_chr_ram,
	output logic [`MMC1_PRG_AW-1:0]  prg_addr,
	output logic                     prg_oe,
	output logic                     rom_ce,
	output logic                     ram_ce,
	output logic                     ram_we,
	output logic [`MMC1_SRM_AW-1:0]  srm_addr
);

	mmc1_pkg::prg_mode_t prg_mode;

	logic [3:0] prg_bank; // 16K bank number
	logic [1:0] srm_bank; // 8K save RAM bank

	assign prg_mode = mmc1_pkg::prg_mode_t'(r0[3:2]);

	// ==================================================
	// PRG bank select
	// ==================================================

	always_comb
	begin
		case (prg_mode)
			mmc1_pkg::prg_fix_first:
			begin
				prg_bank = cpu_addr[14] ? r3[3:0] : 4'h0;
			end
			mmc1_pkg::prg_fix_last:
			begin
				prg_bank = cpu_addr[14] ? 4'hf : r3[3:0];
			end
			default:
			begin
				prg_bank = {r3[3:1], cpu_addr[14]}; // 32K, both modes
			end
		endcase
	end

	// bit 4 of the CHR bank picks the 256K half on SUROM boards
	assign prg_addr[13:0]  = cpu_addr[13:0];
	assign prg_addr[14]    = prg_bank[0];
	assign prg_addr[18:15] = {chr_bank_hi[4], prg_bank[3:1]};

	assign rom_ce = cpu_addr[15];
	assign prg_oe = cpu_rw;

	// ==================================================
	// save RAM at 6000-7FFF
	// ==================================================

	assign ram_ce = (cpu_addr[15:13] == 3'b011) & ~r3[4];
	assign ram_we = ram_ce & ~cpu_rw;

	// banked through CHR bits only when CHR is RAM
	assign srm_bank = cfg_chr_ram ? chr_bank_hi[3:2] : 2'b00;
	assign srm_addr = {srm_bank, cpu_addr[12:0]};

endmodule

// ==== hdl/mmc1_chr_decode.sv ====
`include "mmc1_params.svh"

module mmc1_chr_decode
(
	input  logic [13:0]             ppu_addr,
	input  logic                    ppu_oe,
	input  logic                    ppu_we,
	input  mmc1_pkg::mmc1_reg_t     r0,
	input  mmc1_pkg::mmc1_reg_t     r1,
	input  mmc1_pkg::mmc1_reg_t     r2,
	input  logic                    cfg_chr_ram,
	output logic [4:0]              chr_bank_hi,
	output logic [`MMC1_CHR_AW-1:0] chr_addr,
	output logic                    chr_ce,
	output logic                    chr_oe,
	output logic                    chr_we,
	output logic                    ciram_a10,
	output logic                    ciram_ce
);

	mmc1_pkg::mirror_t mirror;

	// ==================================================
	// CHR bank select
	// ==================================================

	always_comb
	begin
		if (r0[4])
			chr_bank_hi = ppu_addr[12] ? r2 : r1; // two 4K banks
		else
			chr_bank_hi = {r1[4:1], ppu_addr[12]}; // one 8K bank
	end

	assign chr_addr[11:0]  = ppu_addr[11:0];
	assign chr_addr[16:12] = cfg_chr_ram ? {4'b0000, chr_bank_hi[0]} : chr_bank_hi;

	assign ciram_ce = ~ppu_addr[13]; // pattern tables below 2000
	assign chr_ce   = ciram_ce;
	assign chr_oe   = ~ppu_oe;
	assign chr_we   = cfg_chr_ram & ~ppu_we & ciram_ce; // only RAM takes writes

	// ==================================================
	// nametable mirroring
	// ==================================================

	assign mirror = mmc1_pkg::mirror_t'(r0[1:0]);

	always_comb
	begin
		case (mirror)
			mmc1_pkg::single_lo:  ciram_a10 = 1'b0;
			mmc1_pkg::single_hi:  ciram_a10 = 1'b1;
			mmc1_pkg::vertical:   ciram_a10 = ppu_addr[10];
			default:              ciram_a10 = ppu_addr[11]; // horizontal
		endcase
	end

endmodule

// ==== hdl/mmc1_top.sv ====
`include "mmc1_params.svh"

module mmc1_top
(
	input  logic                    m2,
	input  logic                    map_rst,
	input  logic [15:0]             cpu_addr,
	input  logic [7:0]              cpu_dat,
	input  logic                    cpu_rw,
	input  logic [13:0]             ppu_addr,
	input  logic                    ppu_oe,
	input  logic                    ppu_we,
	input  logic                    cfg_chr_ram,
	input  logic                    ss_act,
	input  logic                    ss_we,
	input  logic [7:0]              ss_addr,
	input  logic [7:0]              ss_wdat,
	output logic [`MMC1_PRG_AW-1:0] prg_addr,
	output logic                    prg_oe,
	output logic                    rom_ce,
	output logic                    ram_ce,
	output logic                    ram_we,
	output logic [`MMC1_SRM_AW-1:0] srm_addr,
	output logic [`MMC1_CHR_AW-1:0] chr_addr,
	output logic                    chr_ce,
	output logic                    chr_oe,
	output logic                    chr_we,
	output logic                    ciram_a10,
	output logic                    ciram_ce,
	output logic [7:0]              ss_rdat
);

	logic                load_en;
	mmc1_pkg::mmc1_idx_t load_idx;
	mmc1_pkg::mmc1_reg_t load_val;
	logic                soft_rst;
	mmc1_pkg::mmc1_reg_t buff;

	mmc1_pkg::mmc1_reg_t r0;
	mmc1_pkg::mmc1_reg_t r1;
	mmc1_pkg::mmc1_reg_t r2;
	mmc1_pkg::mmc1_reg_t r3;

	logic [4:0] chr_bank_hi; // CHR bank, also feeds PRG and RAM upper bits

	// ==================================================
	// serial write path and registers
	// ==================================================

	mmc1_shift_loader i_mmc1_shift_loader
	(
		.m2       (m2),
		.map_rst  (map_rst),
		.cpu_addr (cpu_addr),
		.cpu_dat  (cpu_dat),
		.cpu_rw   (cpu_rw),
		.ss_act   (ss_act),
		.ss_we    (ss_we),
		.ss_addr  (ss_addr),
		.ss_wdat  (ss_wdat),
		.load_en  (load_en),
		.load_idx (load_idx),
		.load_val (load_val),
		.soft_rst (soft_rst),
		.buff     (buff)
	);

	mmc1_regs i_mmc1_regs
	(
		.m2       (m2),
		.map_rst  (map_rst),
		.load_en  (load_en),
		.load_idx (load_idx),
		.load_val (load_val),
		.soft_rst (soft_rst),
		.buff     (buff),
		.ss_act   (ss_act),
		.ss_we    (ss_we),
		.ss_addr  (ss_addr),
		.ss_wdat  (ss_wdat),
		.r0       (r0),
		.r1       (r1),
		.r2       (r2),
		.r3       (r3),
		.ss_rdat  (ss_rdat)
	);

	// ==================================================
	// address decoders
	// ==================================================

	mmc1_chr_decode i_mmc1_chr_decode
	(
		.ppu_addr    (ppu_addr),
		.ppu_oe      (ppu_oe),
		.ppu_we      (ppu_we),
		.r0          (r0),
		.r1          (r1),
		.r2          (r2),
		.cfg_chr_ram (cfg_chr_ram),
		.chr_bank_hi (chr_bank_hi),
		.chr_addr    (chr_addr),
		.chr_ce      (chr_ce),
		.chr_oe      (chr_oe),
		.chr_we      (chr_we),
		.ciram_a10   (ciram_a10),
		.ciram_ce    (ciram_ce)
	);

	mmc1_prg_decode i_mmc1_prg_decode
	(
		.cpu_addr    (cpu_addr),
		.cpu_rw      (cpu_rw),
		.r0          (r0),
		.r3          (r3),
		.chr_bank_hi (chr_bank_hi),
		.cfg_chr_ram (cfg_chr_ram),
		.prg_addr    (prg_addr),
		.prg_oe      (prg_oe),
		.rom_ce      (rom_ce),
		.ram_ce      (ram_ce),
		.ram_we      (ram_we),
		.srm_addr    (srm_addr)
	);

endmodule

// ==== test/mmc1_asserts.sv ====
module mmc1_asserts
(
	input logic                m2,
	input logic                map_rst,
	input logic                ss_act,
	input logic                load_en,
	input logic                soft_rst,
	input mmc1_pkg::mmc1_reg_t buff
);

	timeunit 1ns;
	timeprecision 100ps;

	// ==================================================
	// shift loader properties
	// ==================================================

	// a commit is always followed by a filtered or idle cycle
	load_single : assert property (@(posedge m2) disable iff (map_rst)
		load_en |=> !load_en)
		else $error("load_en high in two consecutive cycles");

	strobe_excl : assert property (@(posedge m2)
		!(soft_rst && load_en))
		else $error("soft_rst and load_en high together");

	// save-state writes outrank map_rst
	rst_buff : assert property (@(posedge m2)
		(map_rst && !ss_act) |=> (buff == 5'b10000))
		else $error("buffer not empty after map_rst");

endmodule

bind mmc1_shift_loader mmc1_asserts i_mmc1_asserts
(
	.m2       (m2),
	.map_rst  (map_rst),
	.ss_act   (ss_act),
	.load_en  (load_en),
	.soft_rst (soft_rst),
	.buff     (buff)
);

// ==== test/mmc1_tb.sv ====
`include "mmc1_params.svh"

module mmc1_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int OP_LOAD = 0;
	localparam int OP_RAW  = 1;
	localparam int OP_B7   = 2;
	localparam int OP_DBL  = 3; // two writes back to back
	localparam int OP_SSW  = 4;
	localparam int OP_SSR  = 5;
	localparam int OP_PRB  = 6;

	typedef struct
	{
		int                  op;
		mmc1_pkg::mmc1_idx_t idx;
		logic [7:0]          val;
		logic [15:0]         ca;
		logic [13:0]         pa;
		logic                rw;
		logic                cfg;
	} row_t;

	logic                    m2;
	logic                    map_rst;
	logic [15:0]             cpu_addr;
	logic [7:0]              cpu_dat;
	logic                    cpu_rw;
	logic [13:0]             ppu_addr;
	logic                    ppu_oe;
	logic                    ppu_we;
	logic                    cfg_chr_ram;
	logic                    ss_act;
	logic                    ss_we;
	logic [7:0]              ss_addr;
	logic [7:0]              ss_wdat;
	logic [`MMC1_PRG_AW-1:0] prg_addr;
	logic                    prg_oe;
	logic                    rom_ce;
	logic                    ram_ce;
	logic                    ram_we;
	logic [`MMC1_SRM_AW-1:0] srm_addr;
	logic [`MMC1_CHR_AW-1:0] chr_addr;
	logic                    chr_ce;
	logic                    chr_oe;
	logic                    chr_we;
	logic                    ciram_a10;
	logic                    ciram_ce;
	logic [7:0]              ss_rdat;

	row_t rows [$];
	mmc1_pkg::mmc1_reg_t m_r [4]; // reference registers
	mmc1_pkg::mmc1_reg_t mb;      // reference shift buffer
	int          errors;
	int          row_errs;
	int          cycles;
	int          limit;
	integer      seed;

	mmc1_top i_mmc1_top (.*);

	always #2 m2 = ~m2;

	// run limit
	always @(posedge m2)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
		begin
			$display("timeout, run exceeded %0d cycles", limit);
			$display("Test failed");
			$finish;
		end
	end

	task automatic add_row(int op, mmc1_pkg::mmc1_idx_t idx, logic [7:0] val, logic [15:0] ca,
		logic [13:0] pa, logic rw, logic cfg);
		row_t r;
		r = '{op, idx, val, ca, pa, rw, cfg};
		rows.push_back(r);
	endtask

	// ==================================================
	// reference model
	// ==================================================

	task automatic model_write(mmc1_pkg::mmc1_idx_t idx, logic [7:0] d);
		if (d[7])
		begin
			mb = 5'b10000;
			m_r[0][3:2] = 2'b11;
		end
		else if (mb[0])
		begin
			m_r[idx] = {d[0], mb[4:1]};
			mb = 5'b10000;
		end
		else
			mb = {d[0], mb[4:1]};
	endtask

	function automatic logic [4:0] chr_bank(logic [13:0] pa);
		if (m_r[0][4])
			return pa[12] ? m_r[2] : m_r[1];
		return {m_r[1][4:1], pa[12]};
	endfunction

	function automatic logic [18:0] exp_prg(logic [15:0] ca, logic [13:0] pa);
		logic [3:0] bank;
		logic [4:0] cb;
		mmc1_pkg::prg_mode_t mode;
		mode = mmc1_pkg::prg_mode_t'(m_r[0][3:2]);
		case (mode)
			mmc1_pkg::prg_fix_first: bank = ca[14] ? m_r[3][3:0] : 4'h0;
			mmc1_pkg::prg_fix_last:  bank = ca[14] ? 4'hf : m_r[3][3:0];
			default:                 bank = {m_r[3][3:1], ca[14]};
		endcase
		cb = chr_bank(pa);
		return {cb[4], bank, ca[13:0]};
	endfunction

	function automatic logic exp_a10(logic [13:0] pa);
		mmc1_pkg::mirror_t mir;
		mir = mmc1_pkg::mirror_t'(m_r[0][1:0]);
		case (mir)
			mmc1_pkg::single_lo: return 1'b0;
			mmc1_pkg::single_hi: return 1'b1;
			mmc1_pkg::vertical:  return pa[10];
			default:             return pa[11];
		endcase
	endfunction

	function automatic logic [7:0] exp_ss(logic [7:0] a);
		if (a < 8'd4)
			return {3'b000, m_r[a[1:0]]};
		if (a == 8'd4)
			return {3'b000, mb};
		if (a == 8'd127)
			return 8'h01;
		return 8'hff;
	endfunction

	// ==================================================
	// drive and check
	// ==================================================

	task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			row_errs++;
		end
	endtask

	task automatic cpu_write(mmc1_pkg::mmc1_idx_t idx, logic [7:0] d, bit idle);
		@(negedge m2);
		cpu_addr = {1'b1, idx, 13'h0000};
		cpu_dat = d;
		cpu_rw = 1'b0;
		if (idle)
		begin
			@(negedge m2);
			cpu_rw = 1'b1;
		end
	endtask

	task automatic run_row(row_t r);
		logic [4:0] cb;
		case (r.op)
			OP_LOAD:
			begin
				for (int k = 0; k < 5; k++)
				begin
					cpu_write(r.idx, {7'd0, r.val[k]}, k < 4);
					model_write(r.idx, {7'd0, r.val[k]});
				end
			end
			OP_RAW, OP_B7:
			begin
				cpu_write(r.idx, r.val, 1'b0);
				model_write(r.idx, r.val);
			end
			OP_DBL:
			begin
				cpu_write(r.idx, r.val, 1'b0);
				cpu_write(r.idx, r.val, 1'b0); // filtered
				model_write(r.idx, r.val);
			end
			OP_SSW:
			begin
				@(negedge m2);
				ss_act = 1'b1;
				ss_we = 1'b1;
				ss_addr = {1'b0, r.pa[6:0]};
				ss_wdat = r.val;
				if (r.pa < 14'd4)
					m_r[r.pa[1:0]] = r.val[4:0];
				else if (r.pa == 14'd4)
					mb = r.val[4:0];
			end
			default:
			begin
			end
		endcase
		// probe cycle
		@(negedge m2);
		ss_act = 1'b0;
		ss_we = 1'b0;
		ss_addr = (r.op == OP_SSR) ? r.val : 8'd4;
		cpu_addr = r.ca;
		cpu_rw = r.rw;
		ppu_addr = r.pa;
		cfg_chr_ram = r.cfg;
		ppu_oe = r.ca[0]; // ppu strobes follow the probe row
		ppu_we = r.rw;
		#1;
		cb = chr_bank(r.pa);
		check_val("ss_rdat", 32'(ss_rdat), 32'(exp_ss(ss_addr)));
		if (r.op == OP_SSR || r.op == OP_SSW)
			return;
		check_val("prg_addr", 32'(prg_addr), 32'(exp_prg(r.ca, r.pa)));
		check_val("prg_oe", 32'(prg_oe), 32'(r.rw));
		check_val("rom_ce", 32'(rom_ce), 32'(r.ca[15]));
		check_val("chr_addr", 32'(chr_addr),
			32'(r.cfg ? {4'b0000, cb[0], r.pa[11:0]} : {cb, r.pa[11:0]}));
		check_val("ciram_a10", 32'(ciram_a10), 32'(exp_a10(r.pa)));
		check_val("ciram_ce", 32'(ciram_ce), 32'(!r.pa[13]));
		check_val("chr_ce", 32'(chr_ce), 32'(!r.pa[13]));
		check_val("chr_oe", 32'(chr_oe), 32'(!r.ca[0]));
		check_val("chr_we", 32'(chr_we), 32'(r.cfg && !r.rw && !r.pa[13]));
		check_val("ram_ce", 32'(ram_ce), 32'(r.ca[15:13] == 3'b011 && !m_r[3][4]));
		check_val("ram_we", 32'(ram_we), 32'(r.ca[15:13] == 3'b011 && !m_r[3][4] && !r.rw));
		check_val("srm_addr", 32'(srm_addr),
			32'({(r.cfg ? cb[3:2] : 2'b00), r.ca[12:0]}));
	endtask

	initial
	begin
		logic [31:0] rv;
		m2 = 1'b0;
		map_rst = 1'b1;
		cpu_addr = 16'h0000;
		cpu_dat = 8'h00;
		cpu_rw = 1'b1;
		ppu_addr = 14'h0000;
		ppu_oe = 1'b1;
		ppu_we = 1'b0;
		cfg_chr_ram = 1'b0;
		ss_act = 1'b0;
		ss_we = 1'b0;
		ss_addr = 8'd4;
		ss_wdat = 8'h00;
		errors = 0;
		cycles = 0;
		limit = 100000;
		seed = 32'h360c_496c;
		m_r[0] = 5'h1f;
		m_r[3][4] = 1'b0;
		mb = 5'b10000;

		add_row(OP_LOAD, 2'd1, 8'h0a, 16'h8000, 14'h0000, 1'b1, 1'b0);
		add_row(OP_LOAD, 2'd2, 8'h15, 16'h8000, 14'h0000, 1'b1, 1'b0);
		add_row(OP_LOAD, 2'd3, 8'h05, 16'h8000, 14'h0000, 1'b1, 1'b0);
		add_row(OP_LOAD, 2'd0, 8'h00, 16'h8000, 14'h0000, 1'b1, 1'b0);
		add_row(OP_PRB, 2'd0, 8'h00, 16'h8123, 14'h0456, 1'b1, 1'b0);
		add_row(OP_PRB, 2'd0, 8'h00, 16'hc123, 14'h1456, 1'b1, 1'b0);
		add_row(OP_LOAD, 2'd0, 8'h09, 16'h8000, 14'h2400, 1'b1, 1'b0);
		add_row(OP_PRB, 2'd0, 8'h00, 16'hc001, 14'h1c00, 1'b1, 1'b0);
		add_row(OP_LOAD, 2'd0, 8'h1e, 16'h8000, 14'h0c00, 1'b1, 1'b0);
		add_row(OP_PRB, 2'd0, 8'h00, 16'hc7ff, 14'h1800, 1'b1, 1'b0);
		add_row(OP_PRB, 2'd0, 8'h00, 16'h8abc, 14'h2400, 1'b1, 1'b0);
		add_row(OP_LOAD, 2'd0, 8'h16, 16'h8000, 14'h2800, 1'b1, 1'b0);
		add_row(OP_PRB, 2'd0, 8'h00, 16'hc000, 14'h2c00, 1'b1, 1'b0);
		add_row(OP_PRB, 2'd0, 8'h00, 16'h8000, 14'h1400, 1'b1, 1'b1);
		// bit 7 in the middle of a sequence
		add_row(OP_RAW, 2'd3, 8'h01, 16'h8000, 14'h0000, 1'b1, 1'b0);
		add_row(OP_RAW, 2'd3, 8'h00, 16'h8000, 14'h0000, 1'b1, 1'b0);
		add_row(OP_B7, 2'd3, 8'h80, 16'hc000, 14'h0000, 1'b1, 1'b0);
		add_row(OP_PRB, 2'd0, 8'h00, 16'h8000, 14'h1000, 1'b1, 1'b0);
		add_row(OP_LOAD, 2'd3, 8'h13, 16'h6000, 14'h0000, 1'b0, 1'b0);
		add_row(OP_LOAD, 2'd3, 8'h02, 16'h7fff, 14'h1000, 1'b0, 1'b1);
		add_row(OP_PRB, 2'd0, 8'h00, 16'h6abc, 14'h0000, 1'b1, 1'b1);
		add_row(OP_DBL, 2'd1, 8'h01, 16'h8000, 14'h0000, 1'b1, 1'b0);
		add_row(OP_B7, 2'd0, 8'h80, 16'h8000, 14'h0000, 1'b1, 1'b0);
		// horizontal mirroring, a11 and a10 apart
		add_row(OP_LOAD, 2'd0, 8'h03, 16'h8000, 14'h0800, 1'b1, 1'b0);
		add_row(OP_PRB, 2'd0, 8'h00, 16'hc000, 14'h0400, 1'b1, 1'b0);
		// save-state port, address in the pa column
		add_row(OP_SSW, 2'd0, 8'h12, 16'h8000, 14'd0, 1'b1, 1'b0);
		add_row(OP_SSW, 2'd0, 8'h1f, 16'h8000, 14'd1, 1'b1, 1'b0);
		add_row(OP_SSW, 2'd0, 8'h03, 16'h8000, 14'd2, 1'b1, 1'b0);
		add_row(OP_SSW, 2'd0, 8'h08, 16'h8000, 14'd3, 1'b1, 1'b0);
		add_row(OP_SSW, 2'd0, 8'h03, 16'h8000, 14'd4, 1'b1, 1'b0);
		for (int a = 0; a < 5; a++)
			add_row(OP_SSR, 2'd0, 8'(a), 16'h8000, 14'h0000, 1'b1, 1'b0);
		add_row(OP_SSR, 2'd0, 8'd127, 16'h8000, 14'h0000, 1'b1, 1'b0);
		add_row(OP_SSR, 2'd0, 8'd55, 16'h8000, 14'h0000, 1'b1, 1'b0);
		add_row(OP_B7, 2'd0, 8'h80, 16'h8000, 14'h0000, 1'b1, 1'b0);
		// random register sets
		for (int n = 0; n < 6; n++)
		begin
			for (int i = 0; i < 4; i++)
			begin
				rv = $random(seed);
				add_row(OP_LOAD, 2'(i), {3'b000, rv[4:0]}, 16'h8000, 14'h0000, 1'b1, 1'b0);
			end
			rv = $random(seed);
			add_row(OP_PRB, 2'd0, 8'h00, rv[15:0], rv[29:16], 1'b1, rv[30]);
		end
		limit = 16 * rows.size() + 20;

		repeat (2) @(negedge m2);
		map_rst = 1'b0;
		foreach (rows[i])
		begin
			row_errs = 0;
			run_row(rows[i]);
			errors += row_errs;
			$display("row %0d op %0d %s", i, rows[i].op, (row_errs == 0) ? "ok" : "mismatch");
		end
		$display("rows %0d, failing checks %0d", rows.size(), errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hdl
hdl/mmc1_pkg.sv
hdl/mmc1_shift_loader.sv
hdl/mmc1_regs.sv
hdl/mmc1_prg_decode.sv
hdl/mmc1_chr_decode.sv
hdl/mmc1_top.sv
test/mmc1_asserts.sv
test/mmc1_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert --timing
TOP      = mmc1_tb
FILELIST = verilog.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
